/* field_pkg.sv */
`default_nettype none

package field_pkg;

    localparam int FIELD_WIDTH = 32;

    typedef logic [FIELD_WIDTH-1:0] felem_t;

    typedef enum logic [1:0] {
        OP_ADD = 2'b00,
        OP_SUB = 2'b01,
        OP_MUL = 2'b10,
        OP_DIV = 2'b11
    } field_op_e;

    typedef struct packed {
        field_op_e op;
        felem_t    lhs;
        felem_t    rhs;
    } field_req_t;

    // x + y mod p, both operands below p
    function automatic felem_t mod_add(felem_t x, felem_t y, felem_t p);
        logic [FIELD_WIDTH:0] sum;
        sum = {1'b0, x} + {1'b0, y};
        if (sum >= {1'b0, p})
        begin
            sum = sum - {1'b0, p};
        end
        return sum[FIELD_WIDTH-1:0];
    endfunction

    function automatic felem_t mod_sub(felem_t x, felem_t y, felem_t p);
        felem_t diff;
        diff = x - y;
        if (x < y)
        begin
            diff = diff + p;    // wraps back into range
        end
        return diff;
    endfunction

endpackage

`default_nettype wire

/* point_pkg.sv */
`default_nettype none

package point_pkg;

    import field_pkg::*;

    typedef struct packed {
        felem_t x;
        felem_t y;
    } point_t;

    typedef struct packed {
        point_t                 base;
        felem_t                 a;      // curve coefficient
        felem_t                 prime;
        logic [FIELD_WIDTH-1:0] key;
    } ecc_job_t;

    typedef enum logic [4:0] {
        S_IDLE,
        // doubling, 2R
        D_SQ,
        D_DBL,
        D_TPL,
        D_ADDA,
        D_2Y,
        D_DIV,
        D_LSQ,
        D_SUBX,
        D_X3,
        D_DX,
        D_MUL,
        D_Y3,
        // addition, R + P
        A_DX,
        A_DY,
        A_DIV,
        A_LSQ,
        A_SUBX,
        A_X3,
        A_DX3,
        A_MUL,
        A_Y3,
        S_DONE
    } seq_state_e;

endpackage

`default_nettype wire

/* field_mul.sv */
`default_nettype none

module field_mul
    import field_pkg::*;
#(
    parameter int WIDTH = 32
) (
    input  wire logic   i_clk,
    input  wire logic   i_reset,
    input  wire logic   i_start,
    input  wire felem_t i_a,
    input  wire felem_t i_b,
    input  wire felem_t i_prime,
    output logic        o_done,
    output felem_t      o_product
);

    localparam int CW = $clog2(WIDTH + 1);

    felem_t        a_q, b_q, p_q, acc;
    felem_t        acc_dbl, acc_next;
    logic [CW-1:0] steps_left;
    logic          busy;

    assign acc_dbl   = mod_add(acc, acc, p_q);
    assign acc_next  = b_q[WIDTH-1] ? mod_add(acc_dbl, a_q, p_q) : acc_dbl;
    assign o_product = acc;     // held once busy drops

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            busy       <= 1'b0;
            steps_left <= '0;
            o_done     <= 1'b0;
        end
        else
        begin
            o_done <= 1'b0;
            if (!busy && i_start)
            begin
                busy       <= 1'b1;
                steps_left <= CW'(WIDTH);
            end
            else if (busy)
            begin
                steps_left <= steps_left - 1'b1;
                if (steps_left == CW'(1))
                begin
                    busy   <= 1'b0;
                    o_done <= 1'b1;
                end
            end
        end
    end

    // one bit of b per cycle, msb first
    always_ff @(posedge i_clk)
    begin
        if (!busy && i_start)
        begin
            a_q <= i_a;
            b_q <= i_b;
            p_q <= i_prime;
            acc <= '0;
        end
        else if (busy)
        begin
            acc <= acc_next;
            b_q <= b_q << 1;
        end
    end

    operands_reduced: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_start && !busy) |-> ((i_a < i_prime) && (i_b < i_prime)));

endmodule

`default_nettype wire

/* field_inv.sv */
`default_nettype none

module field_inv
    import field_pkg::*;
#(
    parameter int WIDTH = 32
) (
    input  wire logic   i_clk,
    input  wire logic   i_reset,
    input  wire logic   i_start,
    input  wire felem_t i_value,
    input  wire felem_t i_prime,
    output logic        o_done,
    output felem_t      o_inverse
);

    typedef enum logic [1:0] {IV_IDLE, IV_SQR, IV_MUL} inv_state_e;

    localparam int BW = $clog2(WIDTH);

    inv_state_e    state;
    logic [BW-1:0] bit_idx;
    felem_t        base_q, exp_q, res;
    felem_t        mul_b, product;
    logic          mul_start, mul_done;
    logic          bit_end;

    assign mul_b     = (state == IV_MUL) ? base_q : res;
    assign bit_end   = mul_done && ((state == IV_MUL) || !exp_q[WIDTH-1]);
    assign o_inverse = res;

    field_mul #(
        .WIDTH(WIDTH)
    ) u_mul (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_start   (mul_start),
        .i_a       (res),
        .i_b       (mul_b),
        .i_prime   (i_prime),
        .o_done    (mul_done),
        .o_product (product)
    );

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            state     <= IV_IDLE;
            bit_idx   <= '0;
            mul_start <= 1'b0;
            o_done    <= 1'b0;
        end
        else
        begin
            mul_start <= 1'b0;
            o_done    <= 1'b0;
            case (state)
                IV_IDLE:
                begin
                    if (i_start && (i_value == '0))
                    begin
                        o_done <= 1'b1;     // 0 has no inverse, answer 0
                    end
                    else if (i_start)
                    begin
                        state     <= IV_SQR;
                        bit_idx   <= BW'(WIDTH - 1);
                        mul_start <= 1'b1;
                    end
                end
                IV_SQR, IV_MUL:
                begin
                    if (mul_done && !bit_end)
                    begin
                        state     <= IV_MUL;
                        mul_start <= 1'b1;
                    end
                    else if (bit_end && (bit_idx == '0))
                    begin
                        state  <= IV_IDLE;
                        o_done <= 1'b1;
                    end
                    else if (bit_end)
                    begin
                        state     <= IV_SQR;
                        bit_idx   <= bit_idx - 1'b1;
                        mul_start <= 1'b1;
                    end
                end
                default:
                begin
                    state <= IV_IDLE;
                end
            endcase
        end
    end

    // exponent p-2 scanned msb first
    always_ff @(posedge i_clk)
    begin
        if ((state == IV_IDLE) && i_start)
        begin
            base_q <= i_value;
            exp_q  <= i_prime - felem_t'(2);
            res    <= (i_value == '0) ? '0 : felem_t'(1);
        end
        else if (mul_done)
        begin
            res <= product;
            if (bit_end)
            begin
                exp_q <= exp_q << 1;
            end
        end
    end

endmodule

`default_nettype wire

/* field_unit.sv */
`default_nettype none

module field_unit
    import field_pkg::*;
#(
    parameter int WIDTH = 32
) (
    input  wire logic       i_clk,
    input  wire logic       i_reset,
    input  wire logic       i_req_valid,
    input  wire field_req_t i_req,
    input  wire felem_t     i_prime,
    output logic            o_done,
    output felem_t          o_result
);

    typedef enum logic [1:0] {U_IDLE, U_ARITH, U_INV, U_MUL} unit_state_e;

    unit_state_e state;
    felem_t      lhs_q, arith_q;
    felem_t      mul_a, mul_b, product, inverse;
    logic        accept;
    logic        mul_start, mul_done;
    logic        inv_start, inv_done;

    assign accept    = (state == U_IDLE) && i_req_valid;
    assign inv_start = accept && (i_req.op == OP_DIV);
    // divide reuses the multiplier once the inverse is ready
    assign mul_start = (accept && (i_req.op == OP_MUL)) || ((state == U_INV) && inv_done);
    assign mul_a     = (state == U_INV) ? lhs_q : i_req.lhs;
    assign mul_b     = (state == U_INV) ? inverse : i_req.rhs;

    field_mul #(
        .WIDTH(WIDTH)
    ) u_mul (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_start   (mul_start),
        .i_a       (mul_a),
        .i_b       (mul_b),
        .i_prime   (i_prime),
        .o_done    (mul_done),
        .o_product (product)
    );

    field_inv #(
        .WIDTH(WIDTH)
    ) u_inv (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_start   (inv_start),
        .i_value   (i_req.rhs),
        .i_prime   (i_prime),
        .o_done    (inv_done),
        .o_inverse (inverse)
    );

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            state <= U_IDLE;
        end
        else
        begin
            case (state)
                U_IDLE:
                begin
                    if (i_req_valid)
                    begin
                        case (i_req.op)
                            OP_MUL:  state <= U_MUL;
                            OP_DIV:  state <= U_INV;
                            default: state <= U_ARITH;
                        endcase
                    end
                end
                U_ARITH: state <= U_IDLE;   // done cycle
                U_INV:   state <= inv_done ? U_MUL : U_INV;
                U_MUL:   state <= mul_done ? U_IDLE : U_MUL;
                default: state <= U_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (accept)
        begin
            lhs_q   <= i_req.lhs;
            arith_q <= (i_req.op == OP_SUB) ? mod_sub(i_req.lhs, i_req.rhs, i_prime)
                                            : mod_add(i_req.lhs, i_req.rhs, i_prime);
        end
    end

    assign o_done   = (state == U_ARITH) || ((state == U_MUL) && mul_done);
    assign o_result = (state == U_ARITH) ? arith_q : product;

    sub_done_when_busy: assert property (@(posedge i_clk) disable iff (i_reset)
        (mul_done || inv_done) |-> (state != U_IDLE));

endmodule

`default_nettype wire

/* point_sequencer.sv */
`default_nettype none

module point_sequencer
    import field_pkg::*;
    import point_pkg::*;
#(
    parameter int KEY_BITS = 32
) (
    input  wire logic     i_clk,
    input  wire logic     i_reset,
    input  wire logic     i_start,
    input  wire ecc_job_t i_job,
    output logic          o_busy,
    output logic          o_done,
    output point_t        o_result,
    output logic          o_req_valid,
    output field_req_t    o_req,
    output felem_t        o_prime,
    input  wire logic     i_fdone,
    input  wire felem_t   i_fresult
);

    localparam int CW = $clog2(KEY_BITS);

    seq_state_e    state;
    logic [CW-1:0] bit_idx;
    ecc_job_t      job_q;
    felem_t        x1, y1;      // accumulator R
    felem_t        x2, y2;      // base point P
    felem_t        x3, r1, r2;
    logic          key_bit, last_bit, pt_end;

    assign x2       = job_q.base.x;
    assign y2       = job_q.base.y;
    assign key_bit  = job_q.key[bit_idx];
    assign last_bit = (bit_idx == '0);
    // the doubling's y3 step hands over to the add when the bit is set
    assign pt_end   = i_fdone && ((state == A_Y3) || ((state == D_Y3) && !key_bit));

    assign o_busy      = (state != S_IDLE);
    assign o_done      = (state == S_DONE);
    assign o_req_valid = o_busy && !o_done;
    assign o_prime     = job_q.prime;

    always_comb
    begin
        case (state)
            D_SQ:    o_req = '{OP_MUL, x1, x1};
            D_DBL:   o_req = '{OP_ADD, r1, r1};
            D_TPL:   o_req = '{OP_ADD, r1, r2};
            D_ADDA:  o_req = '{OP_ADD, r1, job_q.a};
            D_2Y:    o_req = '{OP_ADD, y1, y1};
            D_DIV:   o_req = '{OP_DIV, r1, r2};    // slope
            D_LSQ:   o_req = '{OP_MUL, r1, r1};
            D_SUBX:  o_req = '{OP_SUB, r2, x1};
            D_X3:    o_req = '{OP_SUB, r2, x1};
            D_DX:    o_req = '{OP_SUB, x1, x3};
            D_MUL:   o_req = '{OP_MUL, r1, r2};
            D_Y3:    o_req = '{OP_SUB, r1, y1};
            A_DX:    o_req = '{OP_SUB, x2, x1};
            A_DY:    o_req = '{OP_SUB, y2, y1};
            A_DIV:   o_req = '{OP_DIV, r2, r1};    // slope
            A_LSQ:   o_req = '{OP_MUL, r1, r1};
            A_SUBX:  o_req = '{OP_SUB, r2, x1};
            A_X3:    o_req = '{OP_SUB, r2, x2};
            A_DX3:   o_req = '{OP_SUB, x1, x3};
            A_MUL:   o_req = '{OP_MUL, r1, r2};
            A_Y3:    o_req = '{OP_SUB, r2, y1};
            default: o_req = '{OP_ADD, r1, r1};
        endcase
    end

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            state   <= S_IDLE;
            bit_idx <= '0;
        end
        else
        begin
            case (state)
                S_IDLE:
                begin
                    if (i_start)
                    begin
                        state   <= D_SQ;
                        bit_idx <= CW'(KEY_BITS - 2);   // top bit taken as 1
                    end
                end
                S_DONE:
                begin
                    state <= S_IDLE;
                end
                default:
                begin
                    if (pt_end && last_bit)
                    begin
                        state <= S_DONE;
                    end
                    else if (pt_end)
                    begin
                        state   <= D_SQ;
                        bit_idx <= bit_idx - 1'b1;
                    end
                    else if (i_fdone)
                    begin
                        state <= seq_state_e'(state + 1'b1);    // D_Y3 falls into A_DX
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clk)
    begin
        if ((state == S_IDLE) && i_start)
        begin
            job_q <= i_job;
            x1    <= i_job.base.x;
            y1    <= i_job.base.y;
        end
        else if (i_fdone)
        begin
            case (state)
                D_SQ, D_TPL, D_ADDA, D_DIV, D_MUL, A_DX, A_DIV:
                begin
                    r1 <= i_fresult;
                end
                D_DBL, D_2Y, D_LSQ, D_SUBX, D_DX, A_DY, A_LSQ, A_SUBX, A_DX3, A_MUL:
                begin
                    r2 <= i_fresult;
                end
                D_X3, A_X3:
                begin
                    x3 <= i_fresult;
                end
                D_Y3, A_Y3:
                begin
                    x1 <= x3;           // y3 goes straight into R
                    y1 <= i_fresult;
                end
                default:
                begin
                end
            endcase
            if (pt_end && last_bit)
            begin
                o_result <= '{x: x3, y: i_fresult};
            end
        end
    end

    req_held: assert property (@(posedge i_clk) disable iff (i_reset)
        (o_req_valid && !i_fdone) |=> (o_req_valid && $stable(o_req)));

    fdone_when_pending: assert property (@(posedge i_clk) disable iff (i_reset)
        i_fdone |-> o_req_valid);

endmodule

`default_nettype wire

/* ecc_scalar_mult.sv */
`default_nettype none

module ecc_scalar_mult
    import field_pkg::*;
    import point_pkg::*;
#(
    parameter int WIDTH    = 32,
    parameter int KEY_BITS = 32
) (
    input  wire logic     i_clk,
    input  wire logic     i_reset,
    input  wire logic     i_start,
    input  wire ecc_job_t i_job,
    output logic          o_busy,
    output logic          o_done,
    output point_t        o_result
);

    logic       req_valid;
    field_req_t req;
    felem_t     prime;
    logic       fdone;
    felem_t     fresult;

    point_sequencer #(
        .KEY_BITS(KEY_BITS)
    ) u_seq (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_start     (i_start),
        .i_job       (i_job),
        .o_busy      (o_busy),
        .o_done      (o_done),
        .o_result    (o_result),
        .o_req_valid (req_valid),
        .o_req       (req),
        .o_prime     (prime),
        .i_fdone     (fdone),
        .i_fresult   (fresult)
    );

    field_unit #(
        .WIDTH(WIDTH)
    ) u_field (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_req_valid (req_valid),
        .i_req       (req),
        .i_prime     (prime),
        .o_done      (fdone),
        .o_result    (fresult)
    );

endmodule

`default_nettype wire

/* tb_ecc_scalar_mult.sv */
`default_nettype none

module tb_ecc_scalar_mult
    import field_pkg::*;
    import point_pkg::*;
();

    localparam int     KEY_BITS = 32;
    localparam int     NUM_JOBS = 19;
    localparam longint TIMEOUT  = longint'(NUM_JOBS) * KEY_BITS * 6000 * 10;

    logic     i_clk;
    logic     i_reset;
    logic     i_start;
    ecc_job_t i_job;
    logic     o_busy;
    logic     o_done;
    point_t   o_result;

    point_t   exp_q[$];     // expected results, oldest first

    ecc_scalar_mult uut (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_start  (i_start),
        .i_job    (i_job),
        .o_busy   (o_busy),
        .o_done   (o_done),
        .o_result (o_result)
    );

    function automatic felem_t addmod(felem_t x, felem_t y, felem_t p);
        logic [63:0] s;
        s = 64'(x) + 64'(y);
        return felem_t'(s % 64'(p));
    endfunction

    function automatic felem_t submod(felem_t x, felem_t y, felem_t p);
        logic [63:0] s;
        s = 64'(x) + 64'(p) - 64'(y);
        return felem_t'(s % 64'(p));
    endfunction

    function automatic felem_t mulmod(felem_t x, felem_t y, felem_t p);
        logic [63:0] s;
        s = 64'(x) * 64'(y);
        return felem_t'(s % 64'(p));
    endfunction

    function automatic felem_t powmod(felem_t b, felem_t e, felem_t p);
        felem_t r;
        r = 32'd1;
        for (int i = 31; i >= 0; i--)
        begin
            r = mulmod(r, r, p);
            if (e[i])
            begin
                r = mulmod(r, b, p);
            end
        end
        return r;
    endfunction

    // x / y as x * y^(p-2), with 1/0 taken as 0
    function automatic felem_t divmod(felem_t x, felem_t y, felem_t p);
        felem_t inv;
        inv = (y == '0) ? '0 : powmod(y, p - 32'd2, p);
        return mulmod(x, inv, p);
    endfunction

    function automatic point_t point_double(point_t r, felem_t a, felem_t p);
        felem_t t1, t2, x3;
        point_t q;
        t1  = mulmod(r.x, r.x, p);
        t2  = addmod(t1, t1, p);
        t1  = addmod(t1, t2, p);
        t1  = addmod(t1, a, p);
        t2  = addmod(r.y, r.y, p);
        t1  = divmod(t1, t2, p);     // slope
        t2  = mulmod(t1, t1, p);
        t2  = submod(t2, r.x, p);
        x3  = submod(t2, r.x, p);
        t2  = submod(r.x, x3, p);
        t1  = mulmod(t1, t2, p);
        q.x = x3;
        q.y = submod(t1, r.y, p);
        return q;
    endfunction

    function automatic point_t point_add(point_t r, point_t b, felem_t p);
        felem_t t1, t2, x3;
        point_t q;
        t1  = submod(b.x, r.x, p);
        t2  = submod(b.y, r.y, p);
        t1  = divmod(t2, t1, p);
        t2  = mulmod(t1, t1, p);
        t2  = submod(t2, r.x, p);
        x3  = submod(t2, b.x, p);
        t2  = submod(r.x, x3, p);
        t2  = mulmod(t1, t2, p);
        q.x = x3;
        q.y = submod(t2, r.y, p);
        return q;
    endfunction

    // msb of the key is always treated as set
    function automatic point_t scalar_mult_ref(ecc_job_t job);
        point_t r;
        r = job.base;
        for (int i = KEY_BITS - 2; i >= 0; i--)
        begin
            r = point_double(r, job.a, job.prime);
            if (job.key[i])
            begin
                r = point_add(r, job.base, job.prime);
            end
        end
        return r;
    endfunction

    function automatic ecc_job_t random_job();
        ecc_job_t j;
        felem_t   p;
        p           = ($urandom % 2) ? 32'hFFFF_FFFB : 32'h7FFF_FFFF;
        j.prime     = p;
        j.base.x    = $urandom % p;
        j.base.y    = $urandom % p;
        j.a         = $urandom % p;
        j.key       = $urandom;
        return j;
    endfunction

    task automatic end_with_failure();
        $display("** FAIL **");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_problem(string what);
        $display("** Error: %s", what);
        end_with_failure();
    endtask

    task automatic report_mismatch(string name, felem_t got, felem_t expected);
        $display("** Error: %s = 0x%08h, expected 0x%08h", name, got, expected);
        end_with_failure();
    endtask

    task automatic start_job(ecc_job_t job);
        @(posedge i_clk);
        i_job   <= job;
        i_start <= 1'b1;
        exp_q.push_back(scalar_mult_ref(job));
        @(posedge i_clk);
        i_start <= 1'b0;
        @(negedge i_clk);
        assert (o_busy) else report_problem("o_busy did not rise after i_start");
    endtask

    task automatic wait_for_done();
        do
        begin
            @(negedge i_clk);
        end
        while (!o_done);
    endtask

    initial
    begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    initial
    begin
        #(TIMEOUT);
        $display("The run timed out before all jobs had finished");
        end_with_failure();
    end

    // compare each result against the oldest accepted job
    always @(negedge i_clk)
    begin
        point_t expected;
        if (!i_reset && o_done)
        begin
            assert (exp_q.size() != 0) else report_problem("o_done pulsed with no job pending");
            expected = exp_q.pop_front();
            assert (o_result.x === expected.x)
            else report_mismatch("o_result.x", o_result.x, expected.x);
            assert (o_result.y === expected.y)
            else report_mismatch("o_result.y", o_result.y, expected.y);
        end
    end

    initial
    begin
        ecc_job_t job;
        ecc_job_t other;
        void'($urandom(33383));
        i_reset    = 1'b1;
        i_start    = 1'b0;
        i_job      = '0;
        repeat (10) @(posedge i_clk);
        i_reset <= 1'b0;

        job.base.x = 32'd5;     // doubling-only chain
        job.base.y = 32'd7;
        job.a      = 32'd3;
        job.prime  = 32'hFFFF_FFFB;
        job.key    = 32'h8000_0000;
        start_job(job);
        wait_for_done();

        repeat (12)
        begin
            start_job(random_job());
            wait_for_done();
        end

        job   = random_job();
        other = random_job();
        start_job(job);
        @(posedge i_clk);
        i_job   <= other;   // must be ignored while busy
        i_start <= 1'b1;
        @(posedge i_clk);
        i_start <= 1'b0;
        wait_for_done();
        repeat (20)
        begin
            @(negedge i_clk);
            assert (!o_busy) else report_problem("second i_start while busy was accepted");
        end

        job        = random_job();
        job.prime  = 32'hFFFF_FFFB;
        job.base.x = $urandom % job.prime;
        job.base.y = '0;
        job.a      = $urandom % job.prime;
        start_job(job);
        wait_for_done();

        start_job(random_job());
        repeat (500) @(posedge i_clk);
        i_reset <= 1'b1;
        exp_q.delete();     // aborted job gives no result
        @(negedge i_clk);
        assert (!o_busy && !o_done) else report_problem("o_busy or o_done high during reset");
        repeat (3) @(posedge i_clk);
        i_reset <= 1'b0;
        start_job(random_job());
        wait_for_done();

        job   = random_job();
        job.a = '0;
        other = random_job();
        other.a = '0;
        start_job(job);
        wait_for_done();
        start_job(other);   // starts in the cycle after o_done
        wait_for_done();

        repeat (5) @(posedge i_clk);
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
field_pkg.sv
point_pkg.sv
field_mul.sv
field_inv.sv
field_unit.sv
point_sequencer.sv
ecc_scalar_mult.sv
tb_ecc_scalar_mult.sv

/* Bender.yml */
package:
  name: ecc_scalar_mult

sources:
  - field_pkg.sv
  - point_pkg.sv
  - field_mul.sv
  - field_inv.sv
  - field_unit.sv
  - point_sequencer.sv
  - ecc_scalar_mult.sv
  - target: simulation
    files:
      - tb_ecc_scalar_mult.sv
